// File: mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// First fetch address after reset
`define MIPS_RESET_PC   32'h0000_3000

// Instruction field positions
`define OP_FIELD        31:26
`define RS_FIELD        25:21
`define RT_FIELD        20:16
`define RD_FIELD        15:11
`define FN_FIELD        5:0
`define IMM_FIELD       15:0

// Opcodes
`define OP_SPECIAL      6'b000000
`define OP_ADDIU        6'b001001
`define OP_ORI          6'b001101
`define OP_LUI          6'b001111
`define OP_LW           6'b100011
`define OP_LH           6'b100001
`define OP_LHU          6'b100101
`define OP_LB           6'b100000
`define OP_LBU          6'b100100
`define OP_SW           6'b101011
`define OP_SH           6'b101001
`define OP_SB           6'b101000

// Funct codes under SPECIAL
`define FN_ADDU         6'b100001
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_SLT          6'b101010

`define REG_COUNT       32

`endif

// File: mipsPkg.sv
package mipsPkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;

    // General register number
    typedef logic [4:0] regAddr_t;

    // One bit per byte lane of a store
    typedef logic [3:0] byteEn_t;

    // ALU function selected in decode
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    // Access size of loads and stores
    typedef enum logic [1:0] {
        memWord = 2'd0,
        memHalf = 2'd1,
        memByte = 2'd2
    } memWidth_t;

endpackage

// File: regFile.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    output word_t    rsVal,
    output word_t    rtVal,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [`REG_COUNT];
    logic  wrActive;

    // Register 0 is never written, so it stays zero
    assign wrActive = (wrAddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrActive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Same-cycle writeback is visible to decode
    assign rsVal = (wrActive && rsAddr == wrAddr) ? wrData : regs[rsAddr];
    assign rtVal = (wrActive && rtAddr == wrAddr) ? wrData : regs[rtAddr];

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module decodeStage
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output word_t     iInstAddr,
    input  word_t     iInstRdata,
    output regAddr_t  rsAddr,
    output regAddr_t  rtAddr,
    input  word_t     rsVal,
    input  word_t     rtVal,
    input  regAddr_t  eDest,
    input  logic      eMemRead,
    output word_t     dPc,
    output word_t     dImm,
    output word_t     dRsVal,
    output word_t     dRtVal,
    output regAddr_t  dRs,
    output regAddr_t  dRt,
    output regAddr_t  dDest,
    output aluOp_t    dAluOp,
    output logic      dUseImm,
    output logic      dZeroExt,
    output logic      dMemRead,
    output logic      dMemWrite,
    output logic      dLoadSigned,
    output memWidth_t dMemWidth,
    output logic      dBubble
);

    word_t       pc;
    word_t       fdInst;
    word_t       fdPc;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic        readsRs;
    logic        readsRt;
    logic        stall;

    assign iInstAddr = pc;

    // PC and fetch/decode register hold while a load-use stall is pending
    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= `MIPS_RESET_PC;
            fdInst <= '0;
            fdPc   <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc     <= pc + 32'd4;
            fdInst <= iInstRdata;
            fdPc   <= pc;
        end
    end

    assign opcode = fdInst[`OP_FIELD];
    assign funct  = fdInst[`FN_FIELD];
    assign imm    = fdInst[`IMM_FIELD];
    assign rsAddr = fdInst[`RS_FIELD];
    assign rtAddr = fdInst[`RT_FIELD];

    always_comb begin
        dAluOp      = aluAdd;
        dUseImm     = 1'b0;
        dZeroExt    = 1'b0;
        dMemRead    = 1'b0;
        dMemWrite   = 1'b0;
        dLoadSigned = 1'b0;
        dMemWidth   = memWord;
        dDest       = '0;
        readsRs     = 1'b0;
        readsRt     = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
                dDest   = fdInst[`RD_FIELD];
                case (funct)
                    `FN_ADDU: dAluOp = aluAdd;
                    `FN_SUBU: dAluOp = aluSub;
                    `FN_AND:  dAluOp = aluAnd;
                    `FN_OR:   dAluOp = aluOr;
                    `FN_SLT:  dAluOp = aluSlt;
                    // Unknown funct retires as a nop
                    default: begin
                        readsRs = 1'b0;
                        readsRt = 1'b0;
                        dDest   = '0;
                    end
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI: begin
                dUseImm  = 1'b1;
                dDest    = rtAddr;
                readsRs  = (opcode != `OP_LUI);
                dZeroExt = (opcode == `OP_ORI);
                if (opcode == `OP_ORI) begin
                    dAluOp = aluOr;
                end else if (opcode == `OP_LUI) begin
                    dAluOp = aluLui;
                end
            end
            `OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU: begin
                dUseImm     = 1'b1;
                dMemRead    = 1'b1;
                readsRs     = 1'b1;
                dDest       = rtAddr;
                dLoadSigned = (opcode == `OP_LH) || (opcode == `OP_LB);
                dMemWidth   = (opcode == `OP_LW) ? memWord :
                              (opcode == `OP_LH || opcode == `OP_LHU) ? memHalf : memByte;
            end
            `OP_SW, `OP_SH, `OP_SB: begin
                dUseImm   = 1'b1;
                dMemWrite = 1'b1;
                readsRs   = 1'b1;
                readsRt   = 1'b1;
                dMemWidth = (opcode == `OP_SW) ? memWord :
                            (opcode == `OP_SH) ? memHalf : memByte;
            end
            default: ;
        endcase
    end

    // Unread sources are reported as register 0 so they never match
    assign dRs    = readsRs ? rsAddr : '0;
    assign dRt    = readsRt ? rtAddr : '0;
    assign dRsVal = rsVal;
    assign dRtVal = rtVal;
    assign dImm   = {{16{imm[15]}}, imm};
    assign dPc    = fdPc;

    // Load in execute feeding this instruction
    assign stall   = eMemRead && (eDest != '0) && ((eDest == dRs) || (eDest == dRt));
    assign dBubble = stall;

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  regAddr_t  dRs,
    input  regAddr_t  dRt,
    input  regAddr_t  dDest,
    input  word_t     dRsVal,
    input  word_t     dRtVal,
    input  word_t     dImm,
    input  aluOp_t    dAluOp,
    input  logic      dUseImm,
    input  logic      dZeroExt,
    input  logic      dMemRead,
    input  logic      dMemWrite,
    input  memWidth_t dMemWidth,
    input  logic      dLoadSigned,
    input  word_t     dPc,
    input  logic      dBubble,
    input  regAddr_t  mDest,
    input  word_t     mAluResult,
    input  regAddr_t  wDest,
    input  word_t     wData,
    output word_t     eAluResult,
    output word_t     eStoreVal,
    output regAddr_t  eDest,
    output logic      eMemRead,
    output logic      eMemWrite,
    output memWidth_t eMemWidth,
    output logic      eLoadSigned,
    output word_t     ePc
);

    regAddr_t eRs;
    regAddr_t eRt;
    word_t    eRsVal;
    word_t    eRtVal;
    word_t    eImm;
    aluOp_t   eAluOp;
    logic     eUseImm;
    logic     eZeroExt;
    word_t    rsFwd;
    word_t    rtFwd;
    word_t    immExt;
    word_t    aluB;

    // Newest producer wins, memory stage before writeback
    function automatic word_t forwardOperand(
        input regAddr_t src,
        input word_t    regVal,
        input regAddr_t memDest,
        input word_t    memVal,
        input regAddr_t wbDest,
        input word_t    wbVal
    );
        word_t result;
        result = regVal;
        if (src != '0 && src == memDest) begin
            result = memVal;
        end else if (src != '0 && src == wbDest) begin
            result = wbVal;
        end
        return result;
    endfunction

    // Bubble clears everything that can change architectural state
    always_ff @(posedge clk) begin
        if (rst || dBubble) begin
            eRs       <= '0;
            eRt       <= '0;
            eDest     <= '0;
            eMemRead  <= 1'b0;
            eMemWrite <= 1'b0;
        end else begin
            eRs       <= dRs;
            eRt       <= dRt;
            eDest     <= dDest;
            eMemRead  <= dMemRead;
            eMemWrite <= dMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        eRsVal      <= dRsVal;
        eRtVal      <= dRtVal;
        eImm        <= dImm;
        eAluOp      <= dAluOp;
        eUseImm     <= dUseImm;
        eZeroExt    <= dZeroExt;
        eMemWidth   <= dMemWidth;
        eLoadSigned <= dLoadSigned;
        ePc         <= dPc;
    end

    assign rsFwd = forwardOperand(eRs, eRsVal, mDest, mAluResult, wDest, wData);
    assign rtFwd = forwardOperand(eRt, eRtVal, mDest, mAluResult, wDest, wData);

    // Decode hands over the sign-extended form
    assign immExt = eZeroExt ? {16'h0000, eImm[15:0]} : eImm;
    assign aluB   = eUseImm ? immExt : rtFwd;

    always_comb begin
        case (eAluOp)
            aluSub:  eAluResult = rsFwd - aluB;
            aluAnd:  eAluResult = rsFwd & aluB;
            aluOr:   eAluResult = rsFwd | aluB;
            aluSlt:  eAluResult = {31'd0, $signed(rsFwd) < $signed(aluB)};
            aluLui:  eAluResult = {aluB[15:0], 16'h0000};
            default: eAluResult = rsFwd + aluB;
        endcase
    end

    assign eStoreVal = rtFwd;

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     eAluResult,
    input  word_t     eStoreVal,
    input  regAddr_t  eDest,
    input  logic      eMemRead,
    input  logic      eMemWrite,
    input  memWidth_t eMemWidth,
    input  logic      eLoadSigned,
    input  word_t     ePc,
    output word_t     mDataAddr,
    output word_t     mDataWdata,
    output byteEn_t   mDataByteen,
    output word_t     mInstAddr,
    input  word_t     mDataRdata,
    output regAddr_t  mDest,
    output word_t     mAluResult,
    output regAddr_t  wDest,
    output word_t     wData,
    output logic      wGrfWe,
    output word_t     wInstAddr
);

    word_t       mStoreVal;
    logic        mMemRead;
    logic        mMemWrite;
    memWidth_t   mMemWidth;
    logic        mLoadSigned;
    word_t       mPc;
    logic [15:0] loadHalf;
    logic [7:0]  loadByte;
    word_t       loadData;
    word_t       wPc;

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (rst) begin
            mDest     <= '0;
            mMemRead  <= 1'b0;
            mMemWrite <= 1'b0;
        end else begin
            mDest     <= eDest;
            mMemRead  <= eMemRead;
            mMemWrite <= eMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        mAluResult  <= eAluResult;
        mStoreVal   <= eStoreVal;
        mMemWidth   <= eMemWidth;
        mLoadSigned <= eLoadSigned;
        mPc         <= ePc;
    end

    assign mDataAddr = mAluResult;
    assign mInstAddr = mPc;

    // Store data copied into every lane, enables pick the live ones
    always_comb begin
        mDataWdata  = mStoreVal;
        mDataByteen = 4'b0000;
        case (mMemWidth)
            memHalf: mDataWdata = {2{mStoreVal[15:0]}};
            memByte: mDataWdata = {4{mStoreVal[7:0]}};
            default: ;
        endcase
        if (mMemWrite) begin
            case (mMemWidth)
                memHalf: mDataByteen = mAluResult[1] ? 4'b1100 : 4'b0011;
                memByte: mDataByteen = 4'b0001 << mAluResult[1:0];
                default: mDataByteen = 4'b1111;
            endcase
        end
    end

    // Lane extraction for sub-word loads
    assign loadHalf = mAluResult[1] ? mDataRdata[31:16] : mDataRdata[15:0];
    assign loadByte = mDataRdata[{mAluResult[1:0], 3'b000} +: 8];

    always_comb begin
        case (mMemWidth)
            memHalf: begin
                loadData = mLoadSigned ? {{16{loadHalf[15]}}, loadHalf}
                                       : {16'h0000, loadHalf};
            end
            memByte: begin
                loadData = mLoadSigned ? {{24{loadByte[7]}}, loadByte}
                                       : {24'h000000, loadByte};
            end
            default: loadData = mDataRdata;
        endcase
    end

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wDest <= '0;
        end else begin
            wDest <= mDest;
        end
    end

    always_ff @(posedge clk) begin
        wData <= mMemRead ? loadData : mAluResult;
        wPc   <= mPc;
    end

    assign wGrfWe    = (wDest != '0);
    assign wInstAddr = wPc;

endmodule

// File: mipsCore.sv
`timescale 1ns/1ps

module mipsCore
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output word_t    iInstAddr,
    input  word_t    iInstRdata,
    output word_t    mDataAddr,
    output word_t    mDataWdata,
    output byteEn_t  mDataByteen,
    output word_t    mInstAddr,
    input  word_t    mDataRdata,
    output logic     wGrfWe,
    output regAddr_t wGrfAddr,
    output word_t    wGrfWdata,
    output word_t    wInstAddr
);

    // Register file read port
    regAddr_t  rsAddr;
    regAddr_t  rtAddr;
    word_t     rsVal;
    word_t     rtVal;

    // Decode to execute
    regAddr_t  dRs;
    regAddr_t  dRt;
    regAddr_t  dDest;
    word_t     dRsVal;
    word_t     dRtVal;
    word_t     dImm;
    word_t     dPc;
    aluOp_t    dAluOp;
    logic      dUseImm;
    logic      dZeroExt;
    logic      dMemRead;
    logic      dMemWrite;
    logic      dLoadSigned;
    memWidth_t dMemWidth;
    logic      dBubble;

    // Execute to memory
    word_t     eAluResult;
    word_t     eStoreVal;
    regAddr_t  eDest;
    logic      eMemRead;
    logic      eMemWrite;
    memWidth_t eMemWidth;
    logic      eLoadSigned;
    word_t     ePc;

    // Forwarding and writeback
    regAddr_t  mDest;
    word_t     mAluResult;
    regAddr_t  wDest;
    word_t     wData;

    decodeStage uDecode (
        .clk, .rst, .iInstAddr, .iInstRdata,
        .rsAddr, .rtAddr, .rsVal, .rtVal, .eDest, .eMemRead,
        .dPc, .dImm, .dRsVal, .dRtVal, .dRs, .dRt, .dDest,
        .dAluOp, .dUseImm, .dZeroExt, .dMemRead, .dMemWrite,
        .dLoadSigned, .dMemWidth, .dBubble
    );

    regFile uRegFile (
        .clk, .rst, .rsAddr, .rtAddr, .rsVal, .rtVal,
        .wrAddr (wDest),
        .wrData (wData)
    );

    executeStage uExecute (
        .clk, .rst, .dRs, .dRt, .dDest, .dRsVal, .dRtVal, .dImm,
        .dAluOp, .dUseImm, .dZeroExt, .dMemRead, .dMemWrite,
        .dMemWidth, .dLoadSigned, .dPc, .dBubble,
        .mDest, .mAluResult, .wDest, .wData,
        .eAluResult, .eStoreVal, .eDest, .eMemRead, .eMemWrite,
        .eMemWidth, .eLoadSigned, .ePc
    );

    memoryStage uMemory (
        .clk, .rst, .eAluResult, .eStoreVal, .eDest, .eMemRead,
        .eMemWrite, .eMemWidth, .eLoadSigned, .ePc,
        .mDataAddr, .mDataWdata, .mDataByteen, .mInstAddr, .mDataRdata,
        .mDest, .mAluResult, .wDest, .wData, .wGrfWe, .wInstAddr
    );

    assign wGrfAddr  = wDest;
    assign wGrfWdata = wData;

endmodule

// File: mipsCore_assert.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsCore_assert
    import mipsPkg::*;
(
    input logic    clk,
    input logic    rst,
    input word_t   iInstAddr,
    input byteEn_t mDataByteen,
    input logic    wGrfWe,
    input word_t   wInstAddr
);

    word_t lastWbPc;

    // Address of the newest retired writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            lastWbPc <= '0;
        end else if (wGrfWe) begin
            lastWbPc <= wInstAddr;
        end
    end

    // Whole word, aligned half or single byte
    byteEnShape: assert property (@(posedge clk) disable iff (rst)
        mDataByteen inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                            4'b1000, 4'b0011, 4'b1100, 4'b1111})
        else $error("Illegal store byte enable %b", mDataByteen);

    // Writebacks retire in program order
    wbOrder: assert property (@(posedge clk) disable iff (rst)
        wGrfWe |-> wInstAddr > lastWbPc)
        else $error("Writeback from %h arrived out of program order", wInstAddr);

    resetState: assert property (@(posedge clk)
        rst |=> (!wGrfWe && mDataByteen == 4'b0000 && iInstAddr == `MIPS_RESET_PC))
        else $error("Core not in its reset state one cycle after reset");

    // No branches, so the PC only stalls or steps
    pcStep: assert property (@(posedge clk) disable iff (rst)
        iInstAddr == $past(iInstAddr) || iInstAddr == $past(iInstAddr) + 32'd4)
        else $error("Fetch address jumped to %h", iInstAddr);

endmodule

// File: mips_tb.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_tb
    import mipsPkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 5;
    localparam int PROG_LEN     = 40;
    localparam int PROG_WORDS   = 64;
    localparam int DRAIN_CYCLES = 8;
    // Reset, worst case of one stall per instruction, pipeline fill and drain
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * PROG_LEN + DRAIN_CYCLES + 16;
    localparam int unsigned SEED = 32'hf468_aabb;

    logic     clk;
    logic     rst;
    word_t    iInstAddr;
    word_t    iInstRdata;
    word_t    mDataAddr;
    word_t    mDataWdata;
    byteEn_t  mDataByteen;
    word_t    mInstAddr;
    word_t    mDataRdata;
    logic     wGrfWe;
    regAddr_t wGrfAddr;
    word_t    wGrfWdata;
    word_t    wInstAddr;

    word_t      progMem [PROG_WORDS];
    logic [7:0] dataMem [256];
    logic [7:0] modelMem [256];

    // Expected writebacks and stores in program order
    word_t    wbPc [$];
    regAddr_t wbReg [$];
    word_t    wbVal [$];
    word_t    stPc [$];
    word_t    stAddr [$];
    byteEn_t  stEn [$];
    word_t    stData [$];

    int errorCount = 0;
    int checkCount = 0;
    int wbSeen;
    int stSeen;

    mipsCore UUT (
        .clk, .rst, .iInstAddr, .iInstRdata, .mDataAddr, .mDataWdata,
        .mDataByteen, .mInstAddr, .mDataRdata, .wGrfWe, .wGrfAddr,
        .wGrfWdata, .wInstAddr
    );

    bind mipsCore mipsCore_assert uAssert (
        .clk         (clk),
        .rst         (rst),
        .iInstAddr   (iInstAddr),
        .mDataByteen (mDataByteen),
        .wGrfWe      (wGrfWe),
        .wInstAddr   (wInstAddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compareValue(input string name, input word_t got, input word_t exp);
        checkCount++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    function automatic word_t laneMask(input byteEn_t en);
        return {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
    endfunction

    function automatic logic [7:0] fillByte(input int addr, input int testId);
        return 8'((addr * 37) ^ (testId * 16 + 90));
    endfunction

    function automatic word_t fetchWord(input word_t addr);
        word_t offset;
        offset = addr - `MIPS_RESET_PC;
        // Anything past the program reads as a zero word, which is a nop
        if (offset[1:0] == 2'b00 && offset < 32'(PROG_WORDS * 4)) begin
            return progMem[offset[7:2]];
        end else begin
            return '0;
        end
    endfunction

    task automatic checkWriteback();
        wbSeen++;
        assert (wbPc.size() > 0) else begin
            $display("Unexpected writeback of %h to register %0d at %0t",
                     wGrfWdata, wGrfAddr, $time);
            errorCount++;
        end
        if (wbPc.size() > 0) begin
            compareValue("wInstAddr", wInstAddr, wbPc.pop_front());
            compareValue("wGrfAddr", {27'd0, wGrfAddr}, {27'd0, wbReg.pop_front()});
            compareValue("wGrfWdata", wGrfWdata, wbVal.pop_front());
        end
    endtask

    task automatic checkStore();
        word_t mask;
        mask = laneMask(mDataByteen);
        stSeen++;
        assert (stPc.size() > 0) else begin
            $display("Unexpected store to address %h at %0t", mDataAddr, $time);
            errorCount++;
        end
        if (stPc.size() > 0) begin
            compareValue("mInstAddr", mInstAddr, stPc.pop_front());
            compareValue("mDataAddr", mDataAddr, stAddr.pop_front());
            compareValue("mDataByteen", {28'd0, mDataByteen}, {28'd0, stEn.pop_front()});
            compareValue("mDataWdata", mDataWdata & mask, stData.pop_front());
        end
        // Enabled lanes go into the data memory
        for (int k = 0; k < 4; k++) begin
            if (mDataByteen[k]) begin
                dataMem[{mDataAddr[7:2], 2'(k)}] = mDataWdata[8 * k +: 8];
            end
        end
    endtask

    task automatic driveInputs();
        logic [7:0] base;
        base       = {mDataAddr[7:2], 2'b00};
        iInstRdata = fetchWord(iInstAddr);
        mDataRdata = {dataMem[base + 8'd3], dataMem[base + 8'd2],
                      dataMem[base + 8'd1], dataMem[base]};
    endtask

    // Outputs are sampled and inputs driven on the falling edge
    initial begin
        iInstRdata = '0;
        mDataRdata = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (wGrfWe) begin
                    checkWriteback();
                end
                if (mDataByteen != 4'b0000) begin
                    checkStore();
                end
            end
            driveInputs();
        end
    end

    function automatic regAddr_t pickReg();
        return regAddr_t'($urandom_range(7, 0));
    endfunction

    function automatic logic [15:0] pickOffset(input logic [5:0] op, input int window);
        logic [15:0] off;
        off = 16'($urandom_range(window - 1, 0));
        if (op == `OP_SW || op == `OP_LW) begin
            off[1:0] = 2'b00;
        end else if (op == `OP_SH || op == `OP_LH || op == `OP_LHU) begin
            off[0] = 1'b0;
        end
        return off;
    endfunction

    function automatic word_t aluInstr();
        logic [5:0] fn;
        case ($urandom_range(4, 0))
            0: fn = `FN_ADDU;
            1: fn = `FN_SUBU;
            2: fn = `FN_AND;
            3: fn = `FN_OR;
            default: fn = `FN_SLT;
        endcase
        return {`OP_SPECIAL, pickReg(), pickReg(), pickReg(), 5'd0, fn};
    endfunction

    function automatic word_t immInstr();
        logic [5:0] op;
        case ($urandom_range(2, 0))
            0: op = `OP_ADDIU;
            1: op = `OP_ORI;
            default: op = `OP_LUI;
        endcase
        return {op, pickReg(), pickReg(), 16'($urandom)};
    endfunction

    function automatic word_t memInstr(input logic isLoad, input int window);
        logic [5:0] op;
        if (isLoad) begin
            case ($urandom_range(4, 0))
                0: op = `OP_LW;
                1: op = `OP_LH;
                2: op = `OP_LHU;
                3: op = `OP_LB;
                default: op = `OP_LBU;
            endcase
        end else begin
            case ($urandom_range(2, 0))
                0: op = `OP_SW;
                1: op = `OP_SH;
                default: op = `OP_SB;
            endcase
        end
        // Base register 0, so the offset is the address
        return {op, 5'd0, pickReg(), pickOffset(op, window)};
    endfunction

    function automatic word_t randomInstr(input int testId);
        int pick;
        pick = int'($urandom_range(99, 0));
        case (testId)
            1: return (pick < 75) ? aluInstr() : immInstr();
            2: return immInstr();
            3: return (pick < 50) ? memInstr(1'b0, 256) : immInstr();
            4: begin
                // Small window so loads mostly hit stored bytes
                if (pick < 35) begin
                    return memInstr(1'b1, 32);
                end else if (pick < 60) begin
                    return memInstr(1'b0, 32);
                end else if (pick < 80) begin
                    return immInstr();
                end
                return aluInstr();
            end
            default: return '0;
        endcase
    endfunction

    task automatic buildProgram(input int testId);
        word_t    inst;
        logic     prevLoad;
        regAddr_t prevRt;
        prevLoad = 1'b0;
        prevRt   = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            progMem[6'(i)] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (prevLoad && $urandom_range(1, 0) == 1) begin
                // Consumer right behind the load forces a stall
                inst = {`OP_SPECIAL, prevRt, pickReg(), pickReg(), 5'd0, `FN_ADDU};
            end else begin
                inst = randomInstr(testId);
            end
            // Load opcodes all start with 100
            prevLoad       = (inst[31:29] == 3'b100);
            prevRt         = inst[`RT_FIELD];
            progMem[6'(i)] = inst;
        end
    endtask

    task automatic initMemories(input int testId);
        for (int a = 0; a < 256; a++) begin
            dataMem[8'(a)]  = fillByte(a, testId);
            modelMem[8'(a)] = fillByte(a, testId);
        end
    endtask

    function automatic word_t loadModel(input logic [5:0] op, input logic [7:0] addr);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = modelMem[addr];
        b1 = modelMem[addr + 8'd1];
        case (op)
            `OP_LW:  return {modelMem[addr + 8'd3], modelMem[addr + 8'd2], b1, b0};
            `OP_LH:  return {{16{b1[7]}}, b1, b0};
            `OP_LHU: return {16'h0000, b1, b0};
            `OP_LB:  return {{24{b0[7]}}, b0};
            default: return {24'h000000, b0};
        endcase
    endfunction

    task automatic storeModel(input word_t pc, input logic [5:0] op,
                              input word_t addr, input word_t val);
        byteEn_t en;
        word_t   data;
        case (op)
            `OP_SW:  en = 4'b1111;
            `OP_SH:  en = 4'b0011 << addr[1:0];
            default: en = 4'b0001 << addr[1:0];
        endcase
        // Value moved up to the addressed lanes, little-endian
        data = (val << (8 * addr[1:0])) & laneMask(en);
        for (int k = 0; k < 4; k++) begin
            if (en[k]) begin
                modelMem[{addr[7:2], 2'(k)}] = data[8 * k +: 8];
            end
        end
        stPc.push_back(pc);
        stAddr.push_back(addr);
        stEn.push_back(en);
        stData.push_back(data);
    endtask

    // Sequential reference of the program
    task automatic runModel();
        word_t    regs [`REG_COUNT];
        word_t    inst;
        word_t    pc;
        word_t    a;
        word_t    b;
        word_t    simm;
        word_t    result;
        word_t    addr;
        regAddr_t dest;
        logic     writes;
        for (int r = 0; r < `REG_COUNT; r++) begin
            regs[5'(r)] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            inst   = progMem[6'(i)];
            pc     = `MIPS_RESET_PC + 32'(4 * i);
            a      = regs[inst[`RS_FIELD]];
            b      = regs[inst[`RT_FIELD]];
            simm   = {{16{inst[15]}}, inst[`IMM_FIELD]};
            addr   = a + simm;
            dest   = inst[`RT_FIELD];
            writes = 1'b1;
            result = '0;
            case (inst[`OP_FIELD])
                `OP_SPECIAL: begin
                    dest = inst[`RD_FIELD];
                    case (inst[`FN_FIELD])
                        `FN_ADDU: result = a + b;
                        `FN_SUBU: result = a - b;
                        `FN_AND:  result = a & b;
                        `FN_OR:   result = a | b;
                        `FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  writes = 1'b0;
                    endcase
                end
                `OP_ADDIU: result = a + simm;
                `OP_ORI:   result = a | {16'h0000, inst[`IMM_FIELD]};
                `OP_LUI:   result = {inst[`IMM_FIELD], 16'h0000};
                `OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU: begin
                    result = loadModel(inst[`OP_FIELD], addr[7:0]);
                end
                `OP_SW, `OP_SH, `OP_SB: begin
                    writes = 1'b0;
                    storeModel(pc, inst[`OP_FIELD], addr, b);
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != '0) begin
                regs[dest] = result;
                wbPc.push_back(pc);
                wbReg.push_back(dest);
                wbVal.push_back(result);
            end
        end
    endtask

    function automatic string testName(input int testId);
        case (testId)
            0: return "reset";
            1: return "alu";
            2: return "immediate";
            3: return "store";
            default: return "load";
        endcase
    endfunction

    task automatic runTest(input int testId);
        int errorsBefore;
        errorsBefore = errorCount;
        wbSeen       = 0;
        stSeen       = 0;
        @(negedge clk);
        rst = 1'b1;
        buildProgram(testId);
        initMemories(testId);
        runModel();
        repeat (RESET_CYCLES) @(negedge clk);
        compareValue("iInstAddr", iInstAddr, `MIPS_RESET_PC);
        compareValue("wGrfWe", {31'd0, wGrfWe}, '0);
        compareValue("mDataByteen", {28'd0, mDataByteen}, '0);
        rst = 1'b0;
        while (wbPc.size() != 0 || stPc.size() != 0) begin
            @(negedge clk);
        end
        // Late extra events show up as unexpected
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("Test %0d %s: %0d writebacks, %0d stores, %0d errors",
                 testId, testName(testId), wbSeen, stSeen, errorCount - errorsBefore);
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(SEED));
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + 40));
        $display("Watchdog expired before all tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
mipsPkg.sv
regFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mipsCore.sv
mipsCore_assert.sv
mips_tb.sv

// File: run.sh
#!/bin/sh
# Compile the pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module mips_tb -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vmips_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
